//--- hdl/core_msg_arbiter.sv
// core message queues and round-robin arbiter
`timescale 1ns/1ns
`default_nettype none

module core_msg_arbiter (
  input  logic                                                   logic_clk,
  input  logic                                                   reset,
  input  pkt_sched_pkg::core_msg_t [pkt_sched_pkg::CORE_COUNT-1:0] core_msg,
  input  logic [pkt_sched_pkg::CORE_COUNT-1:0]                   core_msg_valid,
  output pkt_sched_pkg::arb_msg_t                                arb_msg,
  output logic                                                   arb_valid
);

  import pkt_sched_pkg::*;

  core_msg_t [CORE_COUNT-1:0] heads;
  logic [CORE_COUNT-1:0]      not_empty;
  logic [CORE_COUNT-1:0]      pop;
  logic [CORE_W-1:0]          last_core;
  logic [CORE_W-1:0]          grant_core;
  logic                       grant_valid;

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core
    core_msg_fifo i_fifo (
      .logic_clk (logic_clk),
      .reset     (reset),
      .push      (core_msg_valid[c]),
      .push_msg  (core_msg[c]),
      .pop       (pop[c]),
      .head      (heads[c]),
      .not_empty (not_empty[c])
    );
  end

  assign grant_valid = |not_empty;
  assign grant_core = rr_pick(not_empty, last_core);

  always_comb begin
    pop = '0;
    if (grant_valid) begin
      pop[grant_core] = 1'b1;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (reset) begin
      arb_valid <= 1'b0;
      // core 0 gets the first turn
      last_core <= CORE_W'(CORE_COUNT - 1);
    end else begin
      arb_valid <= grant_valid;
      if (grant_valid) begin
        last_core <= grant_core;
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    arb_msg.core <= grant_core;
    arb_msg.msg <= heads[grant_core];
  end

endmodule

`default_nettype wire

//--- hdl/core_msg_fifo.sv
// per-core completion message queue
`timescale 1ns/1ns
`default_nettype none

module core_msg_fifo (
  input  logic                     logic_clk,
  input  logic                     reset,
  input  logic                     push,
  input  pkt_sched_pkg::core_msg_t push_msg,
  input  logic                     pop,
  output pkt_sched_pkg::core_msg_t head,
  output logic                     not_empty
);

  import pkt_sched_pkg::*;

  core_msg_t            mem [MSG_FIFO_DEPTH];
  logic [MSG_PTR_W-1:0] wr_ptr;
  logic [MSG_PTR_W-1:0] rd_ptr;
  logic [MSG_CNT_W-1:0] count;

  always_ff @(posedge logic_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_msg;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == MSG_PTR_W'(MSG_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == MSG_PTR_W'(MSG_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head = mem[rd_ptr];
  assign not_empty = (count != '0);

endmodule

`default_nettype wire

//--- hdl/dma_scheduler.sv
// slot allocation and descriptor issue
`timescale 1ns/1ns
`default_nettype none

module dma_scheduler (
  input  logic                                  logic_clk,
  input  logic                                  reset,
  input  logic [pkt_sched_pkg::LEN_W-1:0]       rx_pkt_len,
  input  logic                                  rx_pkt_valid,
  input  pkt_sched_pkg::arb_msg_t               arb_msg,
  input  logic                                  arb_valid,
  input  logic [pkt_sched_pkg::SLOT_ADDR_W-1:0] rx_addr,
  input  logic [pkt_sched_pkg::SLOT_ADDR_W-1:0] tx_addr,
  output logic [pkt_sched_pkg::SLOT_W-1:0]      rx_slot,
  output logic [pkt_sched_pkg::SLOT_W-1:0]      tx_slot,
  output logic                                  rx_pkt_ready,
  output pkt_sched_pkg::pkt_desc_t              rx_desc,
  output logic                                  rx_desc_valid,
  output pkt_sched_pkg::pkt_desc_t              tx_desc,
  output logic                                  tx_desc_valid
);

  import pkt_sched_pkg::*;

  logic [CORE_COUNT-1:0][SLOT_COUNT-1:0] busy;
  logic [CORE_COUNT-1:0][SLOT_COUNT-1:0] busy_next;
  logic [CORE_COUNT-1:0]                 core_free;
  logic [CORE_W-1:0]                     last_core;
  logic [CORE_W-1:0]                     pick_core;
  logic [SLOT_W-1:0]                     pick_slot;
  logic                                  pick_found;
  logic                                  rx_accept;

  always_comb begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      core_free[c] = ~&busy[c];
    end
  end

  assign pick_found = |core_free;
  assign pick_core = rr_pick(core_free, last_core);

  // lowest free slot of the chosen core
  always_comb begin
    pick_slot = '0;
    for (int s = SLOT_COUNT - 1; s >= 0; s--) begin
      if (!busy[pick_core][s]) begin
        pick_slot = SLOT_W'(s);
      end
    end
  end

  assign rx_accept = rx_pkt_valid && rx_pkt_ready && pick_found;

  assign rx_slot = pick_slot;
  assign tx_slot = arb_msg.msg.slot;

  // release and allocation never touch the same slot
  always_comb begin
    busy_next = busy;
    if (arb_valid) begin
      busy_next[arb_msg.core][arb_msg.msg.slot] = 1'b0;
    end
    if (rx_accept) begin
      busy_next[pick_core][pick_slot] = 1'b1;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (reset) begin
      busy <= '0;
      last_core <= CORE_W'(CORE_COUNT - 1);
      rx_pkt_ready <= 1'b1;
      rx_desc_valid <= 1'b0;
      tx_desc_valid <= 1'b0;
    end else begin
      busy <= busy_next;
      if (rx_accept) begin
        last_core <= pick_core;
      end
      // ready reflects occupancy after this cycle's updates
      rx_pkt_ready <= ~&busy_next;
      rx_desc_valid <= rx_accept;
      tx_desc_valid <= arb_valid && (arb_msg.msg.op == MSG_SEND);
    end
  end

  always_ff @(posedge logic_clk) begin
    if (rx_accept) begin
      rx_desc.core <= pick_core;
      rx_desc.slot <= pick_slot;
      rx_desc.addr <= {pick_core, rx_addr};
      rx_desc.len <= rx_pkt_len;
    end
    if (arb_valid) begin
      tx_desc.core <= arb_msg.core;
      tx_desc.slot <= arb_msg.msg.slot;
      tx_desc.addr <= {arb_msg.core, tx_addr};
      tx_desc.len <= arb_msg.msg.len;
    end
  end

endmodule

`default_nettype wire

//--- hdl/pkt_sched_pkg.sv
// packet scheduler shared definitions
`default_nettype none

package pkt_sched_pkg;

  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 4;
  localparam int CORE_W = $clog2(CORE_COUNT);
  localparam int SLOT_W = $clog2(SLOT_COUNT);
  localparam int SLOT_ADDR_W = 8;
  localparam int LEN_W = 16;
  // core index sits above the slot buffer address
  localparam int DESC_ADDR_W = CORE_W + SLOT_ADDR_W;

  // one queue entry per slot a core can hold
  localparam int MSG_FIFO_DEPTH = SLOT_COUNT;
  localparam int MSG_PTR_W = $clog2(MSG_FIFO_DEPTH);
  localparam int MSG_CNT_W = $clog2(MSG_FIFO_DEPTH + 1);

  typedef enum logic {
    MSG_DROP = 1'b0,
    MSG_SEND = 1'b1
  } msg_op_t;

  typedef struct packed {
    msg_op_t           op;
    logic [SLOT_W-1:0] slot;
    logic [LEN_W-1:0]  len;
  } core_msg_t;

  typedef struct packed {
    logic [SLOT_W-1:0]      slot;
    logic [SLOT_ADDR_W-1:0] addr;
  } slot_wr_t;

  typedef struct packed {
    logic [CORE_W-1:0]      core;
    logic [SLOT_W-1:0]      slot;
    logic [DESC_ADDR_W-1:0] addr;
    logic [LEN_W-1:0]       len;
  } pkt_desc_t;

  typedef struct packed {
    logic [CORE_W-1:0] core;
    core_msg_t         msg;
  } arb_msg_t;

  // first requesting core after the last one served
  function automatic logic [CORE_W-1:0] rr_pick(input logic [CORE_COUNT-1:0] req,
                                                input logic [CORE_W-1:0] last);
    logic [CORE_W-1:0] pick;
    logic [CORE_W-1:0] cand;
    logic found;
    pick = last;
    found = 1'b0;
    for (int k = 1; k <= CORE_COUNT; k++) begin
      cand = CORE_W'((int'(last) + k) % CORE_COUNT);
      if (!found && req[cand]) begin
        pick = cand;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

endpackage

`default_nettype wire

//--- hdl/pkt_sched_top.sv
// packet scheduler top level
`timescale 1ns/1ns
`default_nettype none

module pkt_sched_top (
  input  logic                                                   logic_clk,
  input  logic                                                   reset,
  input  logic [pkt_sched_pkg::LEN_W-1:0]                        rx_pkt_len,
  input  logic                                                   rx_pkt_valid,
  input  pkt_sched_pkg::slot_wr_t                                slot_wr,
  input  logic                                                   slot_wr_valid,
  input  pkt_sched_pkg::core_msg_t [pkt_sched_pkg::CORE_COUNT-1:0] core_msg,
  input  logic [pkt_sched_pkg::CORE_COUNT-1:0]                   core_msg_valid,
  output logic                                                   rx_pkt_ready,
  output pkt_sched_pkg::pkt_desc_t                               rx_desc,
  output logic                                                   rx_desc_valid,
  output pkt_sched_pkg::pkt_desc_t                               tx_desc,
  output logic                                                   tx_desc_valid
);

  import pkt_sched_pkg::*;

  arb_msg_t               arb_msg;
  logic                   arb_valid;
  logic [SLOT_W-1:0]      rx_slot;
  logic [SLOT_W-1:0]      tx_slot;
  logic [SLOT_ADDR_W-1:0] rx_addr;
  logic [SLOT_ADDR_W-1:0] tx_addr;

  slot_addr_table i_addr_table (
    .logic_clk     (logic_clk),
    .reset         (reset),
    .slot_wr       (slot_wr),
    .slot_wr_valid (slot_wr_valid),
    .rx_slot       (rx_slot),
    .tx_slot       (tx_slot),
    .rx_addr       (rx_addr),
    .tx_addr       (tx_addr)
  );

  core_msg_arbiter i_arbiter (
    .logic_clk      (logic_clk),
    .reset          (reset),
    .core_msg       (core_msg),
    .core_msg_valid (core_msg_valid),
    .arb_msg        (arb_msg),
    .arb_valid      (arb_valid)
  );

  dma_scheduler i_scheduler (
    .logic_clk     (logic_clk),
    .reset         (reset),
    .rx_pkt_len    (rx_pkt_len),
    .rx_pkt_valid  (rx_pkt_valid),
    .arb_msg       (arb_msg),
    .arb_valid     (arb_valid),
    .rx_addr       (rx_addr),
    .tx_addr       (tx_addr),
    .rx_slot       (rx_slot),
    .tx_slot       (tx_slot),
    .rx_pkt_ready  (rx_pkt_ready),
    .rx_desc       (rx_desc),
    .rx_desc_valid (rx_desc_valid),
    .tx_desc       (tx_desc),
    .tx_desc_valid (tx_desc_valid)
  );

endmodule

`default_nettype wire

//--- hdl/slot_addr_table.sv
// slot buffer address table
`timescale 1ns/1ns
`default_nettype none

module slot_addr_table (
  input  logic                                 logic_clk,
  input  logic                                 reset,
  input  pkt_sched_pkg::slot_wr_t              slot_wr,
  input  logic                                 slot_wr_valid,
  input  logic [pkt_sched_pkg::SLOT_W-1:0]     rx_slot,
  input  logic [pkt_sched_pkg::SLOT_W-1:0]     tx_slot,
  output logic [pkt_sched_pkg::SLOT_ADDR_W-1:0] rx_addr,
  output logic [pkt_sched_pkg::SLOT_ADDR_W-1:0] tx_addr
);

  import pkt_sched_pkg::*;

  // one entry per slot number, shared by every core
  logic [SLOT_ADDR_W-1:0] addr_mem [SLOT_COUNT];

  always_ff @(posedge logic_clk) begin
    if (reset) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        addr_mem[i] <= '0;
      end
    end else if (slot_wr_valid) begin
      addr_mem[slot_wr.slot] <= slot_wr.addr;
    end
  end

  // independent lookups for allocation and transmit
  assign rx_addr = addr_mem[rx_slot];
  assign tx_addr = addr_mem[tx_slot];

endmodule

`default_nettype wire

//--- verification/pkt_sched_checker.sv
// scheduler port assertions
`timescale 1ns/1ns
`default_nettype none

module pkt_sched_checker (
  input logic logic_clk,
  input logic reset,
  input logic rx_pkt_valid,
  input logic rx_pkt_ready,
  input logic rx_desc_valid,
  input logic tx_desc_valid
);

  // failed assertion count
  int fail_count = 0;

  // receive descriptor one cycle after each accepted packet
  a_rx_desc_follows: assert property (@(posedge logic_clk) disable iff (reset)
    rx_pkt_valid && rx_pkt_ready |=> rx_desc_valid)
    else begin
      fail_count++;
      $error("rx_desc_valid missing one cycle after an accepted packet");
    end

  // and at no other time
  a_rx_desc_only_after_accept: assert property (@(posedge logic_clk) disable iff (reset)
    !(rx_pkt_valid && rx_pkt_ready) |=> !rx_desc_valid)
    else begin
      fail_count++;
      $error("rx_desc_valid without an accepted packet one cycle earlier");
    end

  a_quiet_after_reset: assert property (@(posedge logic_clk)
    reset |=> !rx_desc_valid && !tx_desc_valid)
    else begin
      fail_count++;
      $error("descriptor strobe active in the cycle after reset");
    end

endmodule

`default_nettype wire

//--- verification/pkt_sched_tb.sv
// packet scheduler testbench
`timescale 1ns/1ns
`default_nettype none

module pkt_sched_tb;

  import pkt_sched_pkg::*;

  localparam int FILL_PKTS = CORE_COUNT * SLOT_COUNT;
  localparam int BURST_PKTS = 40;
  localparam int PKT_TOTAL = FILL_PKTS + 2 * BURST_PKTS;
  localparam int WATCHDOG_CYCLES = PKT_TOTAL * 40 + 200;
  localparam int DRAIN_LIMIT = 400;

  logic                       logic_clk;
  logic                       reset;
  logic [LEN_W-1:0]           rx_pkt_len;
  logic                       rx_pkt_valid;
  slot_wr_t                   slot_wr;
  logic                       slot_wr_valid;
  core_msg_t [CORE_COUNT-1:0] core_msg = '0;
  logic [CORE_COUNT-1:0]      core_msg_valid = '0;
  logic                       rx_pkt_ready;
  pkt_desc_t                  rx_desc;
  logic                       rx_desc_valid;
  pkt_desc_t                  tx_desc;
  logic                       tx_desc_valid;

  integer seed = 8142;
  int cycle = 0;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int test_start_errors = 0;
  int send_count = 0;
  int tx_count = 0;
  int sent_pkts;
  bit respond_en = 1'b0;
  // model of the address table, held slots and pending transmits
  bit [SLOT_ADDR_W-1:0] table_model [SLOT_COUNT];
  bit held [CORE_COUNT][SLOT_COUNT];
  int due [CORE_COUNT][SLOT_COUNT];
  logic [LEN_W-1:0] held_len [CORE_COUNT][SLOT_COUNT];
  logic [LEN_W-1:0] len_q [$];
  pkt_desc_t exp_tx [$];

  pkt_sched_top i_dut (.*);

  bind pkt_sched_top pkt_sched_checker i_checker (.*);

  initial begin
    logic_clk = 1'b0;
    forever #10 logic_clk = ~logic_clk;
  end

  always @(posedge logic_clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge logic_clk);
    $display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("** Error [%0t] %s", $time, msg);
  endtask

  task automatic log_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_start_errors) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  function automatic int held_total();
    int n;
    n = 0;
    foreach (held[c, s]) begin
      n += held[c][s];
    end
    return n;
  endfunction

  task automatic write_table();
    for (int s = 0; s < SLOT_COUNT; s++) begin
      @(negedge logic_clk);
      slot_wr.slot = SLOT_W'(s);
      slot_wr.addr = SLOT_ADDR_W'($random(seed));
      slot_wr_valid = 1'b1;
      table_model[s] = slot_wr.addr;
    end
    @(negedge logic_clk);
    slot_wr_valid = 1'b0;
  endtask

  // offers packets while ready is high, with random idle cycles
  task automatic send_pkts(input int count, input int attempts);
    sent_pkts = 0;
    for (int i = 0; i < attempts && sent_pkts < count; i++) begin
      @(negedge logic_clk);
      rx_pkt_valid = 1'b0;
      if (rx_pkt_ready && ($random(seed) & 3) != 0) begin
        rx_pkt_len = LEN_W'($random(seed));
        rx_pkt_valid = 1'b1;
        len_q.push_back(rx_pkt_len);
        sent_pkts++;
      end
    end
    @(negedge logic_clk);
    rx_pkt_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int limit;
    limit = 0;
    while ((held_total() != 0 || exp_tx.size() != 0) && limit < DRAIN_LIMIT) begin
      @(negedge logic_clk);
      limit++;
    end
    assert (limit < DRAIN_LIMIT)
      else log_failure("slots or transmit descriptors still pending after the drain limit");
    // let trailing DROP messages free their slots
    repeat (8) @(negedge logic_clk);
  endtask

  // descriptor checks, then core responses
  always @(negedge logic_clk) begin
    int idx;
    logic [LEN_W-1:0] exp_len;
    pkt_desc_t exp_desc;
    core_msg_valid = '0;
    if (!reset && rx_desc_valid) begin
      exp_len = len_q.pop_front();
      assert (rx_desc.len == exp_len
              && rx_desc.addr == {rx_desc.core, table_model[rx_desc.slot]})
        else flag_mismatch($sformatf("rx_desc len %h addr %h, expected len %h addr %h",
                                     rx_desc.len, rx_desc.addr, exp_len,
                                     {rx_desc.core, table_model[rx_desc.slot]}));
      assert (!held[rx_desc.core][rx_desc.slot])
        else log_failure($sformatf("rx descriptor reused held slot %0d of core %0d",
                                   rx_desc.slot, rx_desc.core));
      held[rx_desc.core][rx_desc.slot] = 1'b1;
      due[rx_desc.core][rx_desc.slot] = cycle + 2 + $unsigned($random(seed)) % 16;
      held_len[rx_desc.core][rx_desc.slot] = exp_len;
    end
    if (!reset && tx_desc_valid) begin
      idx = -1;
      foreach (exp_tx[i]) begin
        if (idx < 0 && exp_tx[i].core == tx_desc.core) idx = i;
      end
      assert (idx >= 0)
        else log_failure($sformatf("tx descriptor on core %0d without a pending SEND",
                                   tx_desc.core));
      if (idx >= 0) begin
        assert (tx_desc == exp_tx[idx])
          else flag_mismatch($sformatf("tx_desc %h, expected %h", tx_desc, exp_tx[idx]));
        exp_tx.delete(idx);
      end
      tx_count++;
    end
    for (int c = 0; c < CORE_COUNT; c++) begin
      idx = -1;
      for (int s = 0; s < SLOT_COUNT; s++) begin
        if (respond_en && idx < 0 && held[c][s] && due[c][s] <= cycle) idx = s;
      end
      if (idx >= 0) begin
        core_msg[c].slot = SLOT_W'(idx);
        core_msg[c].len = held_len[c][idx];
        core_msg[c].op = ($random(seed) & 1) ? MSG_SEND : MSG_DROP;
        core_msg_valid[c] = 1'b1;
        held[c][idx] = 1'b0;
        if (core_msg[c].op == MSG_SEND) begin
          exp_desc.core = CORE_W'(c);
          exp_desc.slot = SLOT_W'(idx);
          exp_desc.addr = {CORE_W'(c), table_model[idx]};
          exp_desc.len = held_len[c][idx];
          exp_tx.push_back(exp_desc);
          send_count++;
        end
      end
    end
  end

  initial begin
    int wait_cycles;
    rx_pkt_len = '0;
    rx_pkt_valid = 1'b0;
    slot_wr = '0;
    slot_wr_valid = 1'b0;
    reset = 1'b1;
    repeat (5) @(posedge logic_clk);
    @(negedge logic_clk);
    assert (rx_pkt_ready && !rx_desc_valid && !tx_desc_valid)
      else log_failure("outputs not in their idle state after reset");
    reset = 1'b0;
    end_test("reset");

    write_table();
    send_pkts(FILL_PKTS + 1, 100);
    assert (sent_pkts == FILL_PKTS && !rx_pkt_ready)
      else log_failure($sformatf("ready fell after %0d packets instead of %0d",
                                 sent_pkts, FILL_PKTS));
    end_test("fill");

    respond_en = 1'b1;
    wait_cycles = 0;
    while (!rx_pkt_ready && wait_cycles < 40) begin
      @(negedge logic_clk);
      wait_cycles++;
    end
    assert (rx_pkt_ready)
      else log_failure("rx_pkt_ready did not rise after held slots were released");
    wait_drained();
    end_test("release");

    send_pkts(BURST_PKTS, WATCHDOG_CYCLES);
    wait_drained();
    end_test("traffic");

    write_table();
    send_pkts(BURST_PKTS, WATCHDOG_CYCLES);
    wait_drained();
    end_test("rewrite");

    assert (tx_count == send_count && exp_tx.size() == 0 && len_q.size() == 0)
      else log_failure($sformatf("%0d transmit descriptors for %0d SEND messages",
                                 tx_count, send_count));
    assert (i_dut.i_checker.fail_count == 0)
      else log_failure($sformatf("%0d bound port assertions failed",
                                 i_dut.i_checker.fail_count));
    end_test("totals");

    $display("summary: %0d tests, %0d failed, %0d errors, %0d SEND, %0d tx",
             tests, failed_tests, errors, send_count, tx_count);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/pkt_sched_pkg.sv
hdl/slot_addr_table.sv
hdl/core_msg_fifo.sv
hdl/core_msg_arbiter.sv
hdl/dma_scheduler.sv
hdl/pkt_sched_top.sv
verification/pkt_sched_checker.sv
verification/pkt_sched_tb.sv
